//--- Bender.yml
package:
  name: proc

sources:
  - include_dirs:
      - logic
    files:
      - logic/procPkg.sv
      - logic/fetchStage.sv
      - logic/instrDecoder.sv
      - logic/regFile.sv
      - logic/aluUnit.sv
      - logic/dataMemory.sv
      - logic/proc.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/tbProc.sv

//--- logic/aluUnit.sv
// Execute ALU and branch unit
`timescale 1ns/1ps

module aluUnit (
    input  procPkg::idExT idEx,
    output procPkg::wordT aluOut,
    output logic          takeBranch,   // Redirect request
    output procPkg::wordT target        // PC plus 2 plus displacement
);
    import procPkg::*;

    wordT opB;
    logic rsZero;
    logic condMet;

    assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            AluAdd: begin
                aluOut = idEx.rsVal + opB;     // Also LD/ST address
            end
            AluSub: begin
                aluOut = idEx.rsVal - opB;
            end
            AluAnd: begin
                aluOut = idEx.rsVal & opB;
            end
            AluXor: begin
                aluOut = idEx.rsVal ^ opB;
            end
            AluPassB: begin
                aluOut = opB;                  // LBI
            end
            default: begin
                aluOut = '0;
            end
        endcase
    end

    // Zero test on rs for BEQZ and BNEZ
    assign rsZero = (idEx.rsVal == '0);

    assign condMet = idEx.ctrl.jump
                   | (idEx.ctrl.branchZero & rsZero)
                   | (idEx.ctrl.branchNotZero & ~rsZero);

    assign takeBranch = idEx.valid & condMet;   // Bubbles never redirect

    assign target = idEx.pc + 16'd2 + idEx.imm;

endmodule

//--- logic/dataMemory.sv
// Data memory
`timescale 1ns/1ps
`include "proc_params.svh"

module dataMemory (
    input  logic          clk,
    input  procPkg::wordT addr,     // Byte address, bit 0 ignored
    input  procPkg::wordT wrData,
    input  logic          we,
    output procPkg::wordT rdData
);
    import procPkg::*;

    localparam int IdxW = $clog2(`PROC_DMEM_DEPTH);

    wordT mem [`PROC_DMEM_DEPTH];   // Contents undefined until stored
    logic [IdxW-1:0] wordIdx;

    assign wordIdx = addr[IdxW:1];  // Upper address bits wrap

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wrData;
        end
    end

    // Read in the same cycle as the address
    assign rdData = mem[wordIdx];

endmodule

//--- logic/fetchStage.sv
// Fetch stage
`timescale 1ns/1ps
`include "proc_params.svh"

module fetchStage (
    input  logic          clk,
    input  logic          rstN,
    input  logic          progWe,        // Program load strobe
    input  procPkg::wordT progAddr,      // Byte address, bit 0 ignored
    input  procPkg::wordT progData,
    input  logic          redirect,      // Taken branch or jump from execute
    input  procPkg::wordT redirectPc,
    input  logic          stop,          // Halt seen in decode
    output procPkg::wordT pc,
    output procPkg::wordT instr
);
    import procPkg::*;

    localparam int IdxW = $clog2(`PROC_IMEM_DEPTH);

    wordT imem [`PROC_IMEM_DEPTH];   // Program store
    wordT pcNext;

    // Redirect wins over stop
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end else if (stop) begin
            pcNext = pc;                 // Hold after HALT
        end else begin
            pcNext = pc + 16'd2;         // Sequential
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Load port, usable during reset
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr[IdxW:1]] <= progData;
        end
    end

    assign instr = imem[pc[IdxW:1]];     // Async read, word index from PC

endmodule

//--- logic/instrDecoder.sv
// Instruction decoder
`timescale 1ns/1ps

module instrDecoder (
    input  procPkg::wordT instr,
    output procPkg::ctrlT ctrl,
    output procPkg::wordT imm
);
    import procPkg::*;

    opcodeT opcode;
    wordT   imm5;
    wordT   imm8;
    wordT   imm11;

    assign opcode = opcodeT'(instr[15:11]);
    assign imm5   = {{11{instr[4]}}, instr[4:0]};    // I1 format
    assign imm8   = {{8{instr[7]}}, instr[7:0]};     // I2 format
    assign imm11  = {{5{instr[10]}}, instr[10:0]};   // J format

    always_comb begin
        ctrl = '0;                       // No writes, no branch by default
        ctrl.aluOp = AluAdd;
        imm = imm5;
        case (opcode)
            OpHalt: begin
                ctrl.halt = 1'b1;
            end
            OpNop: begin
                ctrl.aluOp = AluAdd;     // Pure bubble
            end
            OpAddi, OpAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.destReg = instr[7:5];
                ctrl.useImm = 1'b1;
                ctrl.aluOp = (opcode == OpAndi) ? AluAnd : AluAdd;
            end
            OpLbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.destReg = instr[10:8];   // LBI writes its rs field
                ctrl.useImm = 1'b1;
                ctrl.aluOp = AluPassB;
                imm = imm8;
            end
            OpAlu: begin
                ctrl.regWrite = 1'b1;
                ctrl.destReg = instr[4:2];
                case (instr[1:0])
                    2'b00: ctrl.aluOp = AluAdd;
                    2'b01: ctrl.aluOp = AluSub;
                    2'b10: ctrl.aluOp = AluXor;
                    default: ctrl.aluOp = AluAnd;
                endcase
            end
            OpLd: begin
                ctrl.regWrite = 1'b1;
                ctrl.destReg = instr[7:5];
                ctrl.useImm = 1'b1;      // Base plus offset
                ctrl.memRead = 1'b1;
            end
            OpSt: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;    // Data from rt field
            end
            OpBeqz: begin
                ctrl.branchZero = 1'b1;
                imm = imm8;
            end
            OpBnez: begin
                ctrl.branchNotZero = 1'b1;
                imm = imm8;
            end
            OpJ: begin
                ctrl.jump = 1'b1;
                imm = imm11;
            end
            default: begin
                ctrl.illegal = 1'b1;     // Unknown opcode traps
                ctrl.halt = 1'b1;
            end
        endcase
    end

endmodule

//--- logic/proc.sv
// Five-stage pipelined processor
`timescale 1ns/1ps

module proc (
    input  logic            clk,
    input  logic            rstN,
    input  logic            progWe,      // Program load strobe
    input  procPkg::wordT   progAddr,
    input  procPkg::wordT   progData,
    output procPkg::commitT commit,      // One entry per retiring register write
    output logic            halted,
    output logic            err
);
    import procPkg::*;

    // Stage registers
    ifIdT  ifId;
    idExT  idEx;
    exMemT exMem;
    memWbT memWb;

    wordT fetchPc;
    wordT fetchInstr;
    ctrlT decCtrl;
    wordT decImm;
    wordT rsVal;
    wordT rtVal;
    wordT exAluOut;
    wordT exTarget;
    logic takeBranch;           // Also the squash for IF/ID and ID/EX
    logic memWe;
    wordT memRdData;
    wordT wbData;
    logic decHalt;
    logic haltSeen;             // HALT already passed decode
    logic stopFetch;
    logic wbHalt;
    logic haltedQ;
    logic errQ;

    fetchStage fetch_i (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .redirect(takeBranch), .redirectPc(exTarget),
        .stop(stopFetch),
        .pc(fetchPc), .instr(fetchInstr)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifId <= '0;
        end else begin
            ifId.valid <= !stopFetch && !takeBranch;
            ifId.pc    <= fetchPc;
            ifId.instr <= fetchInstr;
        end
    end

    instrDecoder decode_i (
        .instr(ifId.instr),
        .ctrl(decCtrl),
        .imm(decImm)
    );

    regFile regs_i (
        .clk(clk), .rstN(rstN),
        .rsIdx(ifId.instr[10:8]), .rtIdx(ifId.instr[7:5]),
        .we(commit.valid), .wrIdx(commit.dest), .wrData(wbData),
        .rsVal(rsVal), .rtVal(rtVal)
    );

    // Stop fetch once a live HALT or illegal opcode is decoded
    assign decHalt   = ifId.valid && decCtrl.halt && !takeBranch;
    assign stopFetch = haltSeen || decHalt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltSeen <= 1'b0;
        end else if (decHalt) begin
            haltSeen <= 1'b1;           // Sticky until reset
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else begin
            idEx.valid <= ifId.valid && !takeBranch;
            idEx.ctrl  <= decCtrl;
            idEx.pc    <= ifId.pc;
            idEx.rsVal <= rsVal;
            idEx.rtVal <= rtVal;
            idEx.imm   <= decImm;
        end
    end

    aluUnit alu_i (
        .idEx(idEx),
        .aluOut(exAluOut),
        .takeBranch(takeBranch),
        .target(exTarget)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.aluOut    <= exAluOut;
            exMem.storeData <= idEx.rtVal;   // ST data register
        end
    end

    assign memWe = exMem.valid && exMem.ctrl.memWrite;

    dataMemory dmem_i (
        .clk(clk),
        .addr(exMem.aluOut),
        .wrData(exMem.storeData),
        .we(memWe),
        .rdData(memRdData)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.valid   <= exMem.valid;
            memWb.ctrl    <= exMem.ctrl;
            memWb.aluOut  <= exMem.aluOut;
            memWb.memData <= memRdData;
        end
    end

    // Writeback select and commit report
    assign wbData = memWb.ctrl.memRead ? memWb.memData : memWb.aluOut;

    always_comb begin
        commit.valid = memWb.valid && memWb.ctrl.regWrite;
        commit.dest  = memWb.ctrl.destReg;
        commit.data  = wbData;
    end

    assign wbHalt = memWb.valid && memWb.ctrl.halt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltedQ <= 1'b0;
            errQ    <= 1'b0;
        end else if (wbHalt) begin
            haltedQ <= 1'b1;
            errQ    <= errQ || memWb.ctrl.illegal;
        end
    end

    // Rise in the writeback cycle, then hold
    assign halted = haltedQ || wbHalt;
    assign err    = errQ || (wbHalt && memWb.ctrl.illegal);

endmodule

//--- logic/procPkg.sv
// Processor shared types
package procPkg;

    typedef logic [15:0] wordT;     // Data word, byte address or PC
    typedef logic [2:0]  regIdxT;   // Register index

    // Instruction formats, opcode always in bits 15:11
    //   I1  rs[10:8] rd[7:5] imm5[4:0]           ADDI ANDI LD, ST stores rd
    //   I2  rs[10:8] imm8[7:0]                   LBI writes rs, BEQZ BNEZ test rs
    //   R   rs[10:8] rt[7:5] rd[4:2] funct[1:0]  00 ADD, 01 SUB, 10 XOR, 11 AND
    //   J   disp11[10:0]
    typedef enum logic [4:0] {
        OpHalt = 5'b00000,
        OpNop  = 5'b00001,
        OpJ    = 5'b00100,
        OpAddi = 5'b01000,
        OpAndi = 5'b01011,
        OpBeqz = 5'b01100,
        OpBnez = 5'b01101,
        OpSt   = 5'b10000,
        OpLd   = 5'b10001,
        OpLbi  = 5'b11000,
        OpAlu  = 5'b11011
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd   = 3'd0,
        AluSub   = 3'd1,   // rs minus operand B
        AluAnd   = 3'd2,
        AluXor   = 3'd3,
        AluPassB = 3'd4    // Immediate straight through
    } aluOpT;

    typedef struct packed {
        logic   regWrite;
        regIdxT destReg;
        aluOpT  aluOp;
        logic   useImm;          // Operand B from imm instead of rt
        logic   memRead;
        logic   memWrite;
        logic   branchZero;
        logic   branchNotZero;
        logic   jump;
        logic   halt;
        logic   illegal;
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        wordT pc;
        wordT rsVal;
        wordT rtVal;
        wordT imm;
    } idExT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        wordT aluOut;
        wordT storeData;
    } exMemT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        wordT aluOut;
        wordT memData;
    } memWbT;

    typedef struct packed {
        logic   valid;
        regIdxT dest;
        wordT   data;
    } commitT;

endpackage

//--- logic/proc_params.svh
// Processor sizing macros
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Instruction memory depth in 16-bit words
`define PROC_IMEM_DEPTH 256

// Data memory depth in 16-bit words
`define PROC_DMEM_DEPTH 256

// Architectural register count
`define PROC_NUM_REGS 8

`endif

//--- logic/regFile.sv
// Register file
`timescale 1ns/1ps
`include "proc_params.svh"

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  procPkg::regIdxT rsIdx,
    input  procPkg::regIdxT rtIdx,
    input  logic            we,       // Writeback strobe
    input  procPkg::regIdxT wrIdx,
    input  procPkg::wordT   wrData,
    output procPkg::wordT   rsVal,
    output procPkg::wordT   rtVal
);
    import procPkg::*;

    wordT regs [`PROC_NUM_REGS];
    logic rsHit;
    logic rtHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `PROC_NUM_REGS; i++) begin
                regs[i] <= '0;           // All registers start at zero
            end
        end else if (we) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Same-cycle write seen by decode
    assign rsHit = we && (wrIdx == rsIdx);
    assign rtHit = we && (wrIdx == rtIdx);

    assign rsVal = rsHit ? wrData : regs[rsIdx];
    assign rtVal = rtHit ? wrData : regs[rtIdx];

endmodule

//--- sim/tbClock.sv
// Testbench clock source
`timescale 1ns/1ps

module tbClock (
    output logic clk
);
    localparam real HalfPeriod = 4.0;   // 8 ns period

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HalfPeriod) clk = ~clk;
    end

endmodule

//--- sim/tbProc.sv
// Processor directed tests
`timescale 1ns/1ps

module tbProc;
    import procPkg::*;

    logic        clk;
    logic        rstN;
    logic        progWe;
    wordT        progAddr;
    wordT        progData;
    commitT      commit;
    logic        halted;
    logic        err;

    wordT        prog[$];               // Program image being built
    commitT      expQ[$];               // Expected retirement order
    commitT      gotQ[$];
    wordT        refRegs [8];           // Reference register state
    wordT        refMem [256];          // Reference data memory by word
    logic [31:0] lfsrState = 32'hcee5_f709;

    tbClock clkGen_i (.clk(clk));

    proc proc_i (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .commit(commit), .halted(halted), .err(err)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return v;
    endfunction

    task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Instruction word builders
    function automatic wordT encI1(opcodeT op, regIdxT rs, regIdxT rd, logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic wordT encI2(opcodeT op, regIdxT rs, logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    function automatic wordT encR(regIdxT rs, regIdxT rt, regIdxT rd, logic [1:0] funct);
        return {OpAlu, rs, rt, rd, funct};
    endfunction

    function automatic wordT sext5(logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    task automatic clearModel();
        prog.delete();
        expQ.delete();
        for (int i = 0; i < 8; i++) begin
            refRegs[i] = '0;            // Registers reset to zero
        end
    endtask

    task automatic expectWrite(input regIdxT rd, input wordT val);
        commitT c;
        c.valid = 1'b1;
        c.dest = rd;
        c.data = val;
        refRegs[rd] = val;
        expQ.push_back(c);
    endtask

    // Emitters that also step the reference model
    task automatic lbi(input regIdxT rd, input logic [7:0] imm8);
        prog.push_back(encI2(OpLbi, rd, imm8));
        expectWrite(rd, {{8{imm8[7]}}, imm8});
    endtask

    task automatic addi(input regIdxT rd, input regIdxT rs, input logic [4:0] imm5);
        prog.push_back(encI1(OpAddi, rs, rd, imm5));
        expectWrite(rd, refRegs[rs] + sext5(imm5));
    endtask

    task automatic andi(input regIdxT rd, input regIdxT rs, input logic [4:0] imm5);
        prog.push_back(encI1(OpAndi, rs, rd, imm5));
        expectWrite(rd, refRegs[rs] & sext5(imm5));
    endtask

    // Funct 00 ADD, 01 SUB, 10 XOR, 11 AND
    task automatic aluRR(input logic [1:0] funct, input regIdxT rd, input regIdxT rs,
                         input regIdxT rt);
        wordT r;
        case (funct)
            2'b00: r = refRegs[rs] + refRegs[rt];
            2'b01: r = refRegs[rs] - refRegs[rt];
            2'b10: r = refRegs[rs] ^ refRegs[rt];
            default: r = refRegs[rs] & refRegs[rt];
        endcase
        prog.push_back(encR(rs, rt, rd, funct));
        expectWrite(rd, r);
    endtask

    task automatic st(input regIdxT rt, input regIdxT rs, input logic [4:0] imm5);
        wordT addr;
        addr = refRegs[rs] + sext5(imm5);
        prog.push_back(encI1(OpSt, rs, rt, imm5));
        refMem[addr[8:1]] = refRegs[rt];
    endtask

    task automatic ld(input regIdxT rd, input regIdxT rs, input logic [4:0] imm5);
        wordT addr;
        addr = refRegs[rs] + sext5(imm5);
        prog.push_back(encI1(OpLd, rs, rd, imm5));
        expectWrite(rd, refMem[addr[8:1]]);
    endtask

    task automatic nops(input int n);
        repeat (n) prog.push_back({OpNop, 11'd0});
    endtask

    // Words that must never retire
    task automatic shadowFill(input int n);
        repeat (n) prog.push_back(encI2(OpLbi, 3'd7, 8'h7e));
    endtask

    task automatic emitHalt();
        prog.push_back({OpHalt, 11'd0});
    endtask

    // Load under reset, run until halted, compare the commit stream
    task automatic loadAndRun(input logic expErr);
        int cycles;
        shadowFill(4);                  // Pad past the last instruction
        @(posedge clk);
        #1;
        rstN = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            progWe = 1'b1;
            progAddr = wordT'(2 * i);
            progData = prog[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        gotQ.delete();
        cycles = 0;
        while (1) begin
            @(negedge clk);
            if (commit.valid) gotQ.push_back(commit);
            if (halted) break;
            cycles++;
            if (cycles > 1000) begin
                $display("Processor did not halt within 1000 cycles");
                $display("Simulation finished: FAIL");
                $fatal(1, "Timeout waiting for halted");
            end
        end
        checkEq("err", 16'(err), 16'(expErr));
        checkEq("commitCount", 16'(gotQ.size()), 16'(expQ.size()));
        for (int i = 0; i < gotQ.size(); i++) begin
            checkEq($sformatf("commit[%0d].dest", i), 16'(gotQ[i].dest), 16'(expQ[i].dest));
            checkEq($sformatf("commit[%0d].data", i), gotQ[i].data, expQ[i].data);
        end
    endtask

    task automatic arithmeticOps();
        clearModel();
        for (int r = 0; r < 4; r++) begin
            lbi(3'd1, 8'(randBits(8)));
            lbi(3'd2, 8'(randBits(8)));
            nops(2);
            addi(3'd3, 3'd1, 5'(randBits(5)));
            andi(3'd4, 3'd2, 5'(randBits(5)));
            nops(2);
            aluRR(2'b00, 3'd5, 3'd3, 3'd4);
            aluRR(2'b01, 3'd6, 3'd3, 3'd4);
            nops(2);
            aluRR(2'b10, 3'd7, 3'd5, 3'd6);
            aluRR(2'b11, 3'd1, 3'd5, 3'd6);
            nops(2);
        end
        emitHalt();
        loadAndRun(1'b0);
    endtask

    // Consumers exactly two slots behind their producers
    task automatic bypassDistance();
        clearModel();
        lbi(3'd1, 8'(randBits(8)));
        nops(2);
        addi(3'd2, 3'd1, 5'(randBits(5)));
        lbi(3'd3, 8'(randBits(8)));
        lbi(3'd4, 8'(randBits(8)));
        aluRR(2'b01, 3'd5, 3'd2, 3'd1);
        lbi(3'd7, 8'(randBits(8)));
        nops(1);
        addi(3'd6, 3'd5, 5'(randBits(5)));
        emitHalt();
        loadAndRun(1'b0);
    endtask

    task automatic memoryRoundTrip();
        clearModel();
        lbi(3'd1, 8'h40);               // Base address
        lbi(3'd2, 8'(randBits(8)));
        lbi(3'd3, 8'(randBits(8)));
        lbi(3'd6, 8'h44);
        nops(2);
        st(3'd2, 3'd1, 5'd0);
        st(3'd3, 3'd1, 5'd2);
        nops(2);
        ld(3'd4, 3'd1, 5'd0);
        ld(3'd5, 3'd1, 5'd2);           // Other address with its own value
        ld(3'd7, 3'd6, 5'h1c);          // Negative offset back to 0x40
        emitHalt();
        loadAndRun(1'b0);
    endtask

    task automatic branchShadow();
        clearModel();
        lbi(3'd1, 8'h00);
        lbi(3'd2, 8'h05);
        nops(2);
        prog.push_back(encI2(OpBeqz, 3'd1, 8'd4));   // Taken over 2
        shadowFill(2);
        lbi(3'd3, 8'h31);
        prog.push_back(encI2(OpBnez, 3'd1, 8'd2));   // Not taken
        lbi(3'd4, 8'h41);
        prog.push_back(encI2(OpBnez, 3'd2, 8'd4));   // Taken over 2
        shadowFill(2);
        lbi(3'd5, 8'h51);
        prog.push_back(encI2(OpBeqz, 3'd2, 8'd2));   // Not taken
        lbi(3'd6, 8'h61);
        prog.push_back({OpJ, 11'd6});                 // Skip 3 words
        shadowFill(3);
        lbi(3'd7, 8'h71);
        emitHalt();
        loadAndRun(1'b0);
    endtask

    task automatic haltStops();
        clearModel();
        lbi(3'd1, 8'(randBits(8)));
        lbi(3'd2, 8'(randBits(8)));
        emitHalt();
        loadAndRun(1'b0);
        repeat (20) begin
            @(negedge clk);
            checkEq("commit.valid", 16'(commit.valid), 16'd0);
            checkEq("halted", 16'(halted), 16'd1);
            checkEq("err", 16'(err), 16'd0);
        end
    endtask

    task automatic illegalOpcode();
        clearModel();
        lbi(3'd1, 8'(randBits(8)));
        nops(2);
        addi(3'd2, 3'd1, 5'(randBits(5)));
        prog.push_back(16'hf800);       // Opcode 11111 is unassigned
        shadowFill(2);
        loadAndRun(1'b1);
        repeat (10) begin
            @(negedge clk);
            checkEq("commit.valid", 16'(commit.valid), 16'd0);
            checkEq("halted", 16'(halted), 16'd1);
            checkEq("err", 16'(err), 16'd1);
        end
    endtask

    initial begin
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        arithmeticOps();
        bypassDistance();
        memoryRoundTrip();
        branchShadow();
        haltStops();
        illegalOpcode();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/procPkg.sv
logic/fetchStage.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/dataMemory.sv
logic/proc.sv
sim/tbClock.sv
sim/tbProc.sv
